//--- sandOverlayPkg.sv
/*
 * Shared definitions for the sand game overlay sprite.
 * Holds the screen and sprite geometry, the colour and state enums,
 * the pixel and status structs, the palette and the rule that fills
 * the picture ROM.
 */

`default_nettype none

package sandOverlayPkg;

    // Visible screen size in pixels.
    localparam logic [9:0] screenW = 10'd640;
    localparam logic [9:0] screenH = 10'd480;

    // One sprite cell covers a 4x4 pixel block.
    localparam int cellShift = 2;

    // ROM layout: 8 cells per word, 160 cells per row, 120 rows per picture.
    localparam int wordsPerRow     = 20;
    localparam int wordsPerPicture = 2400; // 20 words times 120 rows.
    localparam int romDepth        = 9600; // Four pictures.
    localparam int romAddrW        = 14;

    // Overlay colour code stored as 2 bits per cell.
    typedef enum logic [1:0] {
        colorTransparent = 2'd0,
        colorWhite       = 2'd1,
        colorBlack       = 2'd2,
        colorFlame       = 2'd3
    } overlayColor_e;

    // Animation FSM states.
    typedef enum logic {
        animIdle = 1'b0,
        animRun  = 1'b1
    } animState_e;

    typedef struct packed {
        logic [9:0] x; // Screen column.
        logic [9:0] y; // Screen row.
    } pixelReq_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic       active;  // Animation is running.
        logic       flame;   // Flame level for the current frame.
        logic [1:0] picture; // Picture index, 0 to 3.
    } animStatus_t;

    // Fixed palette for the opaque overlay codes.
    localparam rgb_t whiteRgb = '{red: 8'hFF, green: 8'hFF, blue: 8'hFF};
    localparam rgb_t blackRgb = '{red: 8'h00, green: 8'h00, blue: 8'h00};
    localparam rgb_t flameRgb = '{red: 8'hFF, green: 8'h60, blue: 8'h00};

    // Content of one ROM word: low half of addr times an odd constant,
    // with the picture number folded into the top two bits.
    function automatic logic [15:0] spriteWordAt(input logic [13:0] addr);
        logic [31:0] product;
        logic [13:0] pictureNum;
        product    = 32'(addr) * 32'd40503;
        pictureNum = addr / 14'(wordsPerPicture);
        return product[15:0] ^ {pictureNum[1:0], 14'd0};
    endfunction

endpackage

`default_nettype wire

//--- overlayAnimCtrl.sv
/*
 * Overlay animation control.
 * Runs the sprite animation for animLen frames after a trigger,
 * steps through four pictures every holdLen frames and raises the
 * flame level in the frames where a new picture starts.
 */

`timescale 1ns/1ps
`default_nettype none

module overlayAnimCtrl
    import sandOverlayPkg::*;
#(
    parameter int unsigned animLen = 120, // Frames per animation, below 255.
    parameter int unsigned holdLen = 10   // Frames per picture, 1 to 15.
) (
    input  logic        iCLK,
    input  logic        iRESET,
    input  logic        newFrame,   // One-cycle pulse at each frame start.
    input  logic        stall,      // Freezes the animation for the frame.
    input  logic        trollBegin, // Trigger level, sampled at newFrame.
    output animStatus_t status
);

    // Last values each counter takes before it ends or wraps.
    localparam logic [7:0] lastFrame = 8'(animLen - 1);
    localparam logic [3:0] lastHold  = 4'(holdLen - 1);

    animState_e animState;
    logic [7:0] frameCnt;   // Frame steps since the trigger.
    logic [3:0] holdCnt;    // Frames spent on the current picture.
    logic [1:0] pictureIdx;
    logic       flameLvl;
    logic       frameStep;
    logic       holdWrap;

    // The state only moves on frames that are not stalled.
    assign frameStep = newFrame && !stall;
    assign holdWrap  = (holdCnt == lastHold); // Picture changes on this step.

    always_ff @(posedge iCLK) begin
        if (iRESET) begin
            animState  <= animIdle;
            flameLvl   <= 1'b0;
            frameCnt   <= 8'd0;
            holdCnt    <= 4'd0;
            pictureIdx <= 2'd0;
        end else if (frameStep) begin
            if (trollBegin) begin
                // A trigger always restarts from picture 0 with a flame frame.
                animState  <= animRun;
                flameLvl   <= 1'b1;
                frameCnt   <= 8'd0;
                holdCnt    <= 4'd0;
                pictureIdx <= 2'd0;
            end else if (animState == animRun) begin
                if (frameCnt == lastFrame) begin
                    // The animation is over, so take the sprite away.
                    animState <= animIdle;
                    flameLvl  <= 1'b0;
                end else begin
                    frameCnt <= frameCnt + 8'd1;
                    flameLvl <= holdWrap; // Flame with every new picture.
                    if (holdWrap) begin
                        holdCnt    <= 4'd0;
                        pictureIdx <= pictureIdx + 2'd1; // Wraps after picture 3.
                    end else begin
                        holdCnt <= holdCnt + 4'd1;
                    end
                end
            end
        end
    end

    // The sprite is shown exactly while the FSM is running.
    assign status = '{
        active:  (animState == animRun),
        flame:   flameLvl,
        picture: pictureIdx
    };

    // The sand simulation must not be disturbed once the run has ended.
    flameOnlyInRun: assert property (
        @(posedge iCLK) disable iff (iRESET)
        (animState == animIdle) |-> !flameLvl
    ) else $error("Flame level raised while the animation is idle.");

    // The run must end on the step that would reach animLen.
    frameCntInRange: assert property (
        @(posedge iCLK) disable iff (iRESET)
        (animState == animRun) |-> (frameCnt < 8'(animLen))
    ) else $error("Frame counter ran past the animation length.");

endmodule

`default_nettype wire

//--- spriteAddrGen.sv
/*
 * Sprite address generator, first pixel pipeline stage.
 * Maps a screen pixel and the current picture onto a ROM word
 * address and the lane of that pixel inside the word.
 */

`timescale 1ns/1ps
`default_nettype none

module spriteAddrGen
    import sandOverlayPkg::*;
(
    input  logic                iCLK,
    input  pixelReq_t           pixelReq, // Pixel asked for by the video timing.
    input  logic [1:0]          picture,  // Current animation picture.
    output logic [romAddrW-1:0] romAddr,
    output logic [2:0]          laneSel   // Cell position within the word.
);

    logic [7:0]          cellRow; // One sprite row per four screen lines.
    logic [4:0]          wordCol; // Eight cells, 32 pixels, per word.
    logic [romAddrW-1:0] addrNext;

    assign cellRow = pixelReq.y[9:cellShift];
    assign wordCol = pixelReq.x[9:cellShift+3];

    // Pictures are stacked one after another in the ROM.
    assign addrNext = romAddrW'(picture) * romAddrW'(wordsPerPicture)
                    + romAddrW'(cellRow) * romAddrW'(wordsPerRow)
                    + romAddrW'(wordCol);

    always_ff @(posedge iCLK) begin
        romAddr <= addrNext;
        laneSel <= pixelReq.x[cellShift+2:cellShift];
    end

    // Off-screen requests would index a neighbouring picture.
    reqOnScreen: assert property (
        @(posedge iCLK) !$isunknown(pixelReq) |->
            (pixelReq.x < screenW) && (pixelReq.y < screenH)
    ) else $error("Pixel request outside the visible screen.");

endmodule

`default_nettype wire

//--- spriteRom.sv
/*
 * Picture ROM for the overlay sprite.
 * Four pictures of 2400 words, each word holding eight 2-bit cells,
 * read with one cycle of latency.
 */

`timescale 1ns/1ps
`default_nettype none

module spriteRom
    import sandOverlayPkg::*;
(
    input  logic                iCLK,
    input  logic [romAddrW-1:0] romAddr,
    output logic [15:0]         romWord
);

    logic [15:0] mem [romDepth];

    // Contents come from the shared fill rule.
    initial begin
        for (int i = 0; i < romDepth; i++) begin
            mem[i] = spriteWordAt(romAddrW'(i));
        end
    end

    always_ff @(posedge iCLK) begin
        romWord <= mem[romAddr]; // Registered read.
    end

    // The address generator must stay inside the four pictures.
    addrInRange: assert property (
        @(posedge iCLK) !$isunknown(romAddr) |-> (romAddr < romAddrW'(romDepth))
    ) else $error("ROM address beyond the last picture.");

endmodule

`default_nettype wire

//--- spritePixelSel.sv
/*
 * Sprite pixel select, third pixel pipeline stage.
 * Picks the 2-bit cell of the requested pixel out of the ROM word
 * and shows nothing while no animation runs.
 */

`timescale 1ns/1ps
`default_nettype none

module spritePixelSel
    import sandOverlayPkg::*;
(
    input  logic          iCLK,
    input  logic [2:0]    laneSelIn,  // Lane from the address stage.
    input  logic [15:0]   romWord,
    input  logic          active,     // Animation running.
    output overlayColor_e overlayCode
);

    logic [2:0] laneDly; // Lines the lane up with the ROM output.
    logic [1:0] cellBits;

    always_ff @(posedge iCLK) begin
        laneDly <= laneSelIn;
    end

    // Lane 0 sits in the lowest two bits.
    assign cellBits = romWord[{laneDly, 1'b0} +: 2];

    always_ff @(posedge iCLK) begin
        if (active) begin
            overlayCode <= overlayColor_e'(cellBits);
        end else begin
            overlayCode <= colorTransparent; // No sprite outside a run.
        end
    end

endmodule

`default_nettype wire

//--- overlayCompositor.sv
/*
 * Overlay compositor, last pixel pipeline stage.
 * Delays the background colour to meet the sprite lookup and lays
 * the overlay colour over it.
 */

`timescale 1ns/1ps
`default_nettype none

module overlayCompositor
    import sandOverlayPkg::*;
(
    input  logic          iCLK,
    input  rgb_t          bgPixel,     // Background, same cycle as the request.
    input  overlayColor_e overlayCode,
    input  logic          flame,       // Flame cells only show on flame frames.
    output rgb_t          outPixel
);

    rgb_t [2:0] bgPipe; // Three stages to match the lookup latency.
    rgb_t       bgAligned;
    rgb_t       mixColor;

    always_ff @(posedge iCLK) begin
        bgPipe <= {bgPipe[1:0], bgPixel};
    end

    assign bgAligned = bgPipe[2];

    always_comb begin
        unique case (overlayCode)
            colorWhite:  mixColor = whiteRgb;
            colorBlack:  mixColor = blackRgb;
            colorFlame:  mixColor = flame ? flameRgb : bgAligned;
            default:     mixColor = bgAligned; // Transparent lets the sand through.
        endcase
    end

    always_ff @(posedge iCLK) begin
        outPixel <= mixColor;
    end

endmodule

`default_nettype wire

//--- sandOverlayTop.sv
/*
 * Overlay sprite block of the sand game.
 * Ties the animation control to the four-stage pixel path that
 * looks up the sprite and lays it over the sand background.
 */

`timescale 1ns/1ps
`default_nettype none

module sandOverlayTop
    import sandOverlayPkg::*;
#(
    parameter int unsigned animLen = 120,
    parameter int unsigned holdLen = 10
) (
    input  logic      iCLK,
    input  logic      iRESET,
    input  logic      stall,      // Holds the animation for a whole frame.
    input  logic      newFrame,   // Frame start pulse.
    input  logic      trollBegin, // User trigger.
    input  pixelReq_t pixelReq,   // One pixel request per cycle.
    input  rgb_t      bgPixel,    // Sand colour of that pixel.
    output logic      flame,      // Tells the sand simulation to disturb the frame.
    output rgb_t      outPixel    // Mixed colour, four cycles after the request.
);

    animStatus_t         status;
    logic [romAddrW-1:0] romAddr;
    logic [2:0]          laneSel;
    logic [15:0]         romWord;
    overlayColor_e       overlayCode;

    overlayAnimCtrl #(
        .animLen (animLen),
        .holdLen (holdLen)
    ) animCtrl (
        .iCLK       (iCLK),
        .iRESET     (iRESET),
        .newFrame   (newFrame),
        .stall      (stall),
        .trollBegin (trollBegin),
        .status     (status)
    );

    spriteAddrGen addrGen (
        .iCLK     (iCLK),
        .pixelReq (pixelReq),
        .picture  (status.picture),
        .romAddr  (romAddr),
        .laneSel  (laneSel)
    );

    spriteRom rom (
        .iCLK    (iCLK),
        .romAddr (romAddr),
        .romWord (romWord)
    );

    spritePixelSel pixelSel (
        .iCLK        (iCLK),
        .laneSelIn   (laneSel),
        .romWord     (romWord),
        .active      (status.active),
        .overlayCode (overlayCode)
    );

    overlayCompositor compositor (
        .iCLK        (iCLK),
        .bgPixel     (bgPixel),
        .overlayCode (overlayCode),
        .flame       (status.flame),
        .outPixel    (outPixel)
    );

    assign flame = status.flame;

endmodule

`default_nettype wire

//--- tbSandOverlay.sv
/*
 * Testbench for the sand game overlay sprite block.
 * Drives random pixel requests every cycle, steps the animation with
 * frame pulses, triggers, stalls and resets, and checks the flame level
 * and every mixed pixel against a reference model.
 */

`timescale 1ns/1ps
`default_nettype none

module tbSandOverlay
    import sandOverlayPkg::*;
();

    localparam int animLenTb      = 12; // Short animation for a quick run.
    localparam int holdLenTb      = 3;
    localparam int clkPeriod      = 8;
    localparam int pixelsPerFrame = 24; // Checked pixels in each frame.
    localparam int frameCycles    = 4 + pixelsPerFrame;
    localparam int plannedFrames  = 40;
    localparam int timeoutNs      = (plannedFrames * frameCycles + 200) * clkPeriod;

    // One pixel on its way through the DUT pipeline.
    typedef struct packed {
        logic [31:0] due;    // Cycle whose negative edge shows the result.
        logic        chk;    // Cleared for pixels that straddle a status change.
        logic [9:0]  x;
        logic [9:0]  y;
        rgb_t        expPix;
    } pendingPix_t;

    logic      iCLK;
    logic      iRESET;
    logic      stall;
    logic      newFrame;
    logic      trollBegin;
    pixelReq_t pixelReq;
    rgb_t      bgPixel;
    logic      flame;
    rgb_t      outPixel;

    integer      seed = 23;
    int          errCnt = 0;
    int          checkCnt = 0;
    logic [31:0] cycleCnt = 0;
    pendingPix_t pending[$];

    // Reference model of the animation status.
    animStatus_t mStatus;
    int          mStep; // Frame steps since the last trigger.

    sandOverlayTop #(
        .animLen (animLenTb),
        .holdLen (holdLenTb)
    ) uut (
        .iCLK       (iCLK),
        .iRESET     (iRESET),
        .stall      (stall),
        .newFrame   (newFrame),
        .trollBegin (trollBegin),
        .pixelReq   (pixelReq),
        .bgPixel    (bgPixel),
        .flame      (flame),
        .outPixel   (outPixel)
    );

    initial begin
        iCLK = 1'b0;
        forever #(clkPeriod / 2) iCLK = ~iCLK;
    end

    always @(posedge iCLK) cycleCnt <= cycleCnt + 1;

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expVal,
                              input string what);
        checkCnt++;
        if (got !== expVal) begin
            errCnt++;
            $display("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                     $time, what, got, expVal);
        end
    endtask

    // Colour the DUT should show for one pixel under a given status.
    function automatic rgb_t expectedPixel(input pixelReq_t req, input rgb_t bg,
                                           input animStatus_t st);
        int          wordIdx;
        int          lane;
        logic [15:0] word;
        logic [1:0]  code;
        if (!st.active) begin
            return bg; // No sprite outside a run.
        end
        wordIdx = st.picture * wordsPerPicture + (req.y / 4) * wordsPerRow + req.x / 32;
        word    = spriteWordAt(14'(wordIdx));
        lane    = (req.x / 4) % 8; // Eight cells per word, lane 0 lowest.
        code    = word[lane*2 +: 2];
        case (code)
            2'd1:    return whiteRgb;
            2'd2:    return blackRgb;
            2'd3:    return st.flame ? flameRgb : bg; // Flame cells need a flame frame.
            default: return bg;
        endcase
    endfunction

    task automatic modelReset();
        mStatus = '0;
        mStep   = 0;
    endtask

    // One unstalled frame step of the animation rules.
    task automatic modelStep(input logic trig);
        if (trig) begin
            mStep   = 0;
            mStatus = '{active: 1'b1, flame: 1'b1, picture: 2'd0};
        end else if (mStatus.active) begin
            mStep++;
            if (mStep == animLenTb) begin
                mStatus = '0; // Run is over.
            end else begin
                mStatus.flame   = (mStep % holdLenTb) == 0;
                mStatus.picture = 2'((mStep / holdLenTb) % 4);
            end
        end
    endtask

    // Drives one cycle of inputs with a fresh random pixel and queues its result.
    task automatic driveCycle(input logic chk, input logic frameIn,
                              input logic stallIn, input logic trigIn);
        pixelReq_t   req;
        rgb_t        bg;
        pendingPix_t ent;
        @(posedge iCLK);
        #1;
        req.x      = 10'($unsigned($random(seed)) % 640);
        req.y      = 10'($unsigned($random(seed)) % 480);
        bg         = 24'($random(seed));
        pixelReq   = req;
        bgPixel    = bg;
        newFrame   = frameIn;
        stall      = stallIn;
        trollBegin = trigIn;
        ent.due    = cycleCnt + 4; // Sampled at the next edge, out after the fourth.
        ent.chk    = chk && !iRESET;
        ent.x      = req.x;
        ent.y      = req.y;
        ent.expPix = expectedPixel(req, bg, mStatus);
        pending.push_back(ent);
    endtask

    // One frame: a short gap, the frame pulse, then checked random pixels.
    task automatic runFrame(input logic stallIn, input logic trigIn);
        repeat (3) driveCycle(1'b0, 1'b0, stallIn, 1'b0); // These meet the status change.
        driveCycle(1'b0, 1'b1, stallIn, trigIn);
        if (!stallIn) begin
            modelStep(trigIn);
        end
        driveCycle(1'b1, 1'b0, stallIn, 1'b0);
        checkValue(flame, mStatus.flame, "flame level");
        repeat (pixelsPerFrame - 1) driveCycle(1'b1, 1'b0, stallIn, 1'b0);
    endtask

    task automatic applyReset();
        repeat (3) driveCycle(1'b0, 1'b0, 1'b0, 1'b0);
        iRESET = 1'b1;
        modelReset();
        repeat (4) driveCycle(1'b0, 1'b0, 1'b0, 1'b0);
        iRESET = 1'b0;
    endtask

    // Compares each pixel once it has left the pipeline.
    initial begin
        pendingPix_t ent;
        forever begin
            @(negedge iCLK);
            if (pending.size() > 0 && pending[0].due == cycleCnt) begin
                ent = pending.pop_front();
                if (ent.chk) begin
                    checkValue(outPixel, ent.expPix,
                               $sformatf("pixel (%0d,%0d)", ent.x, ent.y));
                end
            end
        end
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the run did not finish within %0d ns.", timeoutNs);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        iRESET     = 1'b1;
        stall      = 1'b0;
        newFrame   = 1'b0;
        trollBegin = 1'b0;
        pixelReq   = '0;
        bgPixel    = '0;
        modelReset();
        repeat (4) driveCycle(1'b0, 1'b0, 1'b0, 1'b0);
        iRESET = 1'b0;

        // Idle frames show only the background.
        repeat (3) runFrame(1'b0, 1'b0);

        // A full run, one step past its end.
        runFrame(1'b0, 1'b1);
        repeat (animLenTb + 1) runFrame(1'b0, 1'b0);

        // Stalled frames freeze the animation, even with a trigger.
        runFrame(1'b0, 1'b1);
        repeat (2) runFrame(1'b0, 1'b0);
        runFrame(1'b1, 1'b0);
        runFrame(1'b1, 1'b1);
        repeat (3) runFrame(1'b0, 1'b0);

        // Restart in the middle of a run, then reset in the middle of another.
        runFrame(1'b0, 1'b1);
        repeat (4) runFrame(1'b0, 1'b0);
        runFrame(1'b0, 1'b1);
        repeat (2) runFrame(1'b0, 1'b0);
        applyReset();
        driveCycle(1'b1, 1'b0, 1'b0, 1'b0);
        checkValue(flame, 1'b0, "flame after reset");
        repeat (2) runFrame(1'b0, 1'b0);

        while (pending.size() != 0) @(posedge iCLK);
        $display("Checks run: %0d, errors: %0d", checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
sandOverlayPkg.sv
overlayAnimCtrl.sv
spriteAddrGen.sv
spriteRom.sv
spritePixelSel.sv
overlayCompositor.sv
sandOverlayTop.sv
tbSandOverlay.sv

//--- Bender.yml
package:
  name: sand_overlay

sources:
  - sandOverlayPkg.sv
  - overlayAnimCtrl.sv
  - spriteAddrGen.sv
  - spriteRom.sv
  - spritePixelSel.sv
  - overlayCompositor.sv
  - sandOverlayTop.sv
  - target: test
    files:
      - tbSandOverlay.sv
